//--- include/cdc_bridge_cfg.svh
// Bridge configuration
// Sizes shared by the crossing FIFOs, the scratch memory and the top level.
// Each crossing holds 2**CDC_LOG_DEPTH entries, and its pointers carry one
// extra wrap bit.

`ifndef CDC_BRIDGE_CFG_SVH
`define CDC_BRIDGE_CFG_SVH

// log2 of the entries per crossing FIFO
`define CDC_LOG_DEPTH 2

// Request address width
`define CDC_ADDR_W 8

// Read and write data width
`define CDC_DATA_W 16

// Words in the scratch memory
// Addresses at or above this count answer with an error
`define CDC_MEM_WORDS 64

`endif

//--- logic/cdc_bridge_pkg.sv
// Bridge types
// Payload structs for the request and response streams, the gray pointer
// type of the crossing FIFOs and the binary to gray conversion that both
// FIFO halves share.

`include "cdc_bridge_cfg.svh"

package cdc_bridge_pkg;

   // Gray pointer with one wrap bit above the entry index
   typedef logic [`CDC_LOG_DEPTH:0] ptr_t;

   // Host request, one word per access
   typedef struct packed {
      logic [`CDC_ADDR_W-1:0] addr;
      logic [`CDC_DATA_W-1:0] wdata;
      logic                   write;
   } req_chan_t;

   // Memory response
   typedef struct packed {
      logic [`CDC_DATA_W-1:0] rdata;
      logic                   err;
   } rsp_chan_t;

   // Adjacent codes differ in exactly one bit
   function automatic ptr_t bin2gray(input ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

endpackage

//--- logic/cdc_fifo_src.sv
// Crossing FIFO, source half
// Holds the entry storage and the gray write pointer. The destination half
// reads the storage through rd_addr_i and returns its gray read pointer,
// which is synchronized here through two flops to decide fullness.

`include "cdc_bridge_cfg.svh"

module cdc_fifo_src #(
   parameter type payload_t = logic
) (
   input  logic                       clk_sys,
   input  logic                       rst_n_i,
   // Local write side
   input  logic                       valid_i,
   output logic                       ready_o,
   input  payload_t                   data_i,
   // Crossing side
   output payload_t                   data_o,
   input  logic [`CDC_LOG_DEPTH-1:0]  rd_addr_i,
   output cdc_bridge_pkg::ptr_t       wptr_o,
   input  cdc_bridge_pkg::ptr_t       rptr_i
);

   localparam int unsigned Depth = 1 << `CDC_LOG_DEPTH;

   // Full when the two top gray bits differ and the rest match
   localparam cdc_bridge_pkg::ptr_t FullMask =
      cdc_bridge_pkg::ptr_t'(3) << (`CDC_LOG_DEPTH - 1);

   payload_t mem_q [Depth];

   cdc_bridge_pkg::ptr_t wbin_q;
   cdc_bridge_pkg::ptr_t wbin_next;
   cdc_bridge_pkg::ptr_t wgray_q;
   cdc_bridge_pkg::ptr_t rptr_sync_q1;
   cdc_bridge_pkg::ptr_t rptr_sync_q2;
   logic                 full;
   logic                 push;

   assign wbin_next = wbin_q + 1'b1;
   assign full      = (rptr_sync_q2 == (wgray_q ^ FullMask));
   assign ready_o   = ~full;
   assign push      = valid_i & ready_o;

   assign wptr_o = wgray_q;
   assign data_o = mem_q[rd_addr_i];

   // Two-stage synchronizer for the returning read pointer
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rptr_sync_q1 <= '0;
         rptr_sync_q2 <= '0;
      end else begin
         rptr_sync_q1 <= rptr_i;
         rptr_sync_q2 <= rptr_sync_q1;
      end
   end

   // Write pointer, binary for addressing and gray for the crossing
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wbin_q  <= '0;
         wgray_q <= '0;
      end else if (push) begin
         wbin_q  <= wbin_next;
         wgray_q <= cdc_bridge_pkg::bin2gray(wbin_next);
      end
   end

   // Entry is written in the same cycle the pointer moves past it
   always_ff @(posedge clk_sys) begin
      if (push) begin
         mem_q[wbin_q[`CDC_LOG_DEPTH-1:0]] <= data_i;
      end
   end

endmodule

//--- logic/cdc_fifo_dst.sv
// Crossing FIFO, destination half
// Synchronizes the gray write pointer through two flops, keeps the read
// pointer in binary and gray form and presents the entry at the read
// address to the local side while the FIFO is not empty.

`include "cdc_bridge_cfg.svh"

module cdc_fifo_dst #(
   parameter type payload_t = logic
) (
   input  logic                       clk_sys,
   input  logic                       rst_n_i,
   // Crossing side
   input  payload_t                   data_i,
   output logic [`CDC_LOG_DEPTH-1:0]  rd_addr_o,
   input  cdc_bridge_pkg::ptr_t       wptr_i,
   output cdc_bridge_pkg::ptr_t       rptr_o,
   // Local read side
   output logic                       valid_o,
   input  logic                       ready_i,
   output payload_t                   data_o
);

   cdc_bridge_pkg::ptr_t rbin_q;
   cdc_bridge_pkg::ptr_t rbin_next;
   cdc_bridge_pkg::ptr_t rgray_q;
   cdc_bridge_pkg::ptr_t wptr_sync_q1;
   cdc_bridge_pkg::ptr_t wptr_sync_q2;
   logic                 pop;

   // Not empty as soon as the synchronized write pointer moves on
   assign valid_o = (wptr_sync_q2 != rgray_q);
   assign pop     = valid_o & ready_i;

   assign rbin_next = rbin_q + 1'b1;
   assign rd_addr_o = rbin_q[`CDC_LOG_DEPTH-1:0];
   assign rptr_o    = rgray_q;

   // Storage lives in the source half, this is a plain read port
   assign data_o = data_i;

   // Two-stage synchronizer for the incoming write pointer
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wptr_sync_q1 <= '0;
         wptr_sync_q2 <= '0;
      end else begin
         wptr_sync_q1 <= wptr_i;
         wptr_sync_q2 <= wptr_sync_q1;
      end
   end

   // Read pointer advances once per accepted transfer
   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rbin_q  <= '0;
         rgray_q <= '0;
      end else if (pop) begin
         rbin_q  <= rbin_next;
         rgray_q <= cdc_bridge_pkg::bin2gray(rbin_next);
      end
   end

endmodule

//--- logic/scratch_mem.sv
// Scratch memory responder
// Serves one read or write per accepted request and answers one cycle
// later. Holds a single response, so a new request is taken only when
// the response register is empty or being drained. Out-of-range
// addresses leave the memory untouched and return an error.

`include "cdc_bridge_cfg.svh"

module scratch_mem (
   input  logic                      clk_sys,
   input  logic                      rst_n_i,
   // Request side
   input  logic                      req_valid_i,
   output logic                      req_ready_o,
   input  cdc_bridge_pkg::req_chan_t req_i,
   // Response side
   output logic                      rsp_valid_o,
   input  logic                      rsp_ready_i,
   output cdc_bridge_pkg::rsp_chan_t rsp_o
);

   localparam int unsigned IdxW = $clog2(`CDC_MEM_WORDS);

   logic [`CDC_DATA_W-1:0]    mem_q [`CDC_MEM_WORDS];
   logic [IdxW-1:0]           idx;
   logic                      in_range;
   logic                      accept;
   logic                      rsp_valid_q;
   cdc_bridge_pkg::rsp_chan_t rsp_q;

   assign idx      = req_i.addr[IdxW-1:0];
   assign in_range = (req_i.addr < `CDC_MEM_WORDS);

   assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
   assign accept      = req_valid_i & req_ready_o;

   assign rsp_valid_o = rsp_valid_q;
   assign rsp_o       = rsp_q;

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rsp_valid_q <= 1'b0;
      end else if (accept) begin
         rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
         rsp_valid_q <= 1'b0;
      end
   end

   // Writes answer with zero data, reads with the stored word
   always_ff @(posedge clk_sys) begin
      if (accept) begin
         rsp_q.err <= ~in_range;
         if (in_range && !req_i.write) begin
            rsp_q.rdata <= mem_q[idx];
         end else begin
            rsp_q.rdata <= '0;
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (accept && in_range && req_i.write) begin
         mem_q[idx] <= req_i.wdata;
      end
   end

endmodule

//--- logic/cdc_bridge_top.sv
// Memory access bridge
// Host requests cross to the scratch memory through one split FIFO and
// the responses come back through a second one. Both crossings use the
// same source and destination halves with different payload types.

`include "cdc_bridge_cfg.svh"

module cdc_bridge_top (
   input  logic                   clk_sys,
   input  logic                   rst_n_i,
   // Host request
   input  logic                   req_valid_i,
   output logic                   req_ready_o,
   input  logic [`CDC_ADDR_W-1:0] req_addr_i,
   input  logic [`CDC_DATA_W-1:0] req_wdata_i,
   input  logic                   req_write_i,
   // Host response
   output logic                   rsp_valid_o,
   input  logic                   rsp_ready_i,
   output logic [`CDC_DATA_W-1:0] rsp_rdata_o,
   output logic                   rsp_err_o
);

   // Request crossing
   cdc_bridge_pkg::req_chan_t       host_req;
   cdc_bridge_pkg::req_chan_t       req_xing_data;
   logic [`CDC_LOG_DEPTH-1:0]       req_rd_addr;
   cdc_bridge_pkg::ptr_t            req_wptr;
   cdc_bridge_pkg::ptr_t            req_rptr;

   // Memory side
   logic                            mem_req_valid;
   logic                            mem_req_ready;
   cdc_bridge_pkg::req_chan_t       mem_req;
   logic                            mem_rsp_valid;
   logic                            mem_rsp_ready;
   cdc_bridge_pkg::rsp_chan_t       mem_rsp;

   // Response crossing
   cdc_bridge_pkg::rsp_chan_t       rsp_xing_data;
   logic [`CDC_LOG_DEPTH-1:0]       rsp_rd_addr;
   cdc_bridge_pkg::ptr_t            rsp_wptr;
   cdc_bridge_pkg::ptr_t            rsp_rptr;
   cdc_bridge_pkg::rsp_chan_t       host_rsp;

   assign host_req.addr  = req_addr_i;
   assign host_req.wdata = req_wdata_i;
   assign host_req.write = req_write_i;

   cdc_fifo_src #(.payload_t(cdc_bridge_pkg::req_chan_t)) i_req_src (
      .clk_sys   (clk_sys),
      .rst_n_i   (rst_n_i),
      .valid_i   (req_valid_i),
      .ready_o   (req_ready_o),
      .data_i    (host_req),
      .data_o    (req_xing_data),
      .rd_addr_i (req_rd_addr),
      .wptr_o    (req_wptr),
      .rptr_i    (req_rptr)
   );

   cdc_fifo_dst #(.payload_t(cdc_bridge_pkg::req_chan_t)) i_req_dst (
      .clk_sys   (clk_sys),
      .rst_n_i   (rst_n_i),
      .data_i    (req_xing_data),
      .rd_addr_o (req_rd_addr),
      .wptr_i    (req_wptr),
      .rptr_o    (req_rptr),
      .valid_o   (mem_req_valid),
      .ready_i   (mem_req_ready),
      .data_o    (mem_req)
   );

   scratch_mem i_mem (
      .clk_sys     (clk_sys),
      .rst_n_i     (rst_n_i),
      .req_valid_i (mem_req_valid),
      .req_ready_o (mem_req_ready),
      .req_i       (mem_req),
      .rsp_valid_o (mem_rsp_valid),
      .rsp_ready_i (mem_rsp_ready),
      .rsp_o       (mem_rsp)
   );

   cdc_fifo_src #(.payload_t(cdc_bridge_pkg::rsp_chan_t)) i_rsp_src (
      .clk_sys   (clk_sys),
      .rst_n_i   (rst_n_i),
      .valid_i   (mem_rsp_valid),
      .ready_o   (mem_rsp_ready),
      .data_i    (mem_rsp),
      .data_o    (rsp_xing_data),
      .rd_addr_i (rsp_rd_addr),
      .wptr_o    (rsp_wptr),
      .rptr_i    (rsp_rptr)
   );

   cdc_fifo_dst #(.payload_t(cdc_bridge_pkg::rsp_chan_t)) i_rsp_dst (
      .clk_sys   (clk_sys),
      .rst_n_i   (rst_n_i),
      .data_i    (rsp_xing_data),
      .rd_addr_o (rsp_rd_addr),
      .wptr_i    (rsp_wptr),
      .rptr_o    (rsp_rptr),
      .valid_o   (rsp_valid_o),
      .ready_i   (rsp_ready_i),
      .data_o    (host_rsp)
   );

   assign rsp_rdata_o = host_rsp.rdata;
   assign rsp_err_o   = host_rsp.err;

endmodule

//--- sim/cdc_bridge_checker.sv
// Crossing FIFO checker
// Concurrent assertions bound into both FIFO halves. They watch the gray
// pointer that the half drives, the handshake on its local side and the
// true occupancy seen from both raw pointers.

`include "cdc_bridge_cfg.svh"

module cdc_bridge_checker (
   input logic                 clk_sys,
   input logic                 rst_n_i,
   input cdc_bridge_pkg::ptr_t gray_ptr_i,
   input cdc_bridge_pkg::ptr_t peer_ptr_i,
   input logic                 src_side_i,
   input logic                 valid_i,
   input logic                 ready_i
);

   localparam int unsigned Depth = 1 << `CDC_LOG_DEPTH;

   // Read by the testbench during the run
   int unsigned fail_count = 0;

   cdc_bridge_pkg::ptr_t level;

   function automatic cdc_bridge_pkg::ptr_t gray2bin(input cdc_bridge_pkg::ptr_t g);
      cdc_bridge_pkg::ptr_t b;
      b[`CDC_LOG_DEPTH] = g[`CDC_LOG_DEPTH];
      for (int i = `CDC_LOG_DEPTH - 1; i >= 0; i--) begin
         b[i] = b[i + 1] ^ g[i];
      end
      return b;
   endfunction

   // Entries written and not yet read, from the raw pointers
   assign level = src_side_i ? gray2bin(gray_ptr_i) - gray2bin(peer_ptr_i)
                             : gray2bin(peer_ptr_i) - gray2bin(gray_ptr_i);

   // Gray code may move by one step per cycle at most
   property gray_single_step;
      @(posedge clk_sys) disable iff (!rst_n_i)
         $countones(gray_ptr_i ^ $past(gray_ptr_i)) <= 1;
   endproperty

   // A pending transfer keeps its valid until it is taken
   property valid_held;
      @(posedge clk_sys) disable iff (!rst_n_i)
         (valid_i && !ready_i) |=> valid_i;
   endproperty

   // A full source half must not accept
   property no_ready_when_full;
      @(posedge clk_sys) disable iff (!rst_n_i)
         (src_side_i && level == cdc_bridge_pkg::ptr_t'(Depth)) |-> !ready_i;
   endproperty

   // An empty destination half must not offer data
   property no_valid_when_empty;
      @(posedge clk_sys) disable iff (!rst_n_i)
         (!src_side_i && level == '0) |-> !valid_i;
   endproperty

   a_gray_single_step : assert property (gray_single_step)
      else begin
         fail_count++;
         $error("gray pointer changed by more than one bit");
      end

   a_valid_held : assert property (valid_held)
      else begin
         fail_count++;
         $error("valid dropped before the transfer");
      end

   a_no_ready_when_full : assert property (no_ready_when_full)
      else begin
         fail_count++;
         $error("ready high while the FIFO is full");
      end

   a_no_valid_when_empty : assert property (no_valid_when_empty)
      else begin
         fail_count++;
         $error("valid high while the FIFO is empty");
      end

endmodule

//--- sim/cdc_bridge_tb.sv
// Bridge testbench
// Drives host requests from a table through the bridge, collects the
// responses in order and compares them with a reference memory model.
// Covers reset state, in-range and out-of-range accesses, a back-to-back
// burst and response back-pressure.

`include "cdc_bridge_cfg.svh"

module cdc_bridge_tb;

   localparam int Depth       = 1 << `CDC_LOG_DEPTH;
   localparam int IdxW        = $clog2(`CDC_MEM_WORDS);
   localparam int ReqTimeout  = 200;
   localparam int RspTimeout  = 200;
   localparam int BpTimeout   = 400;
   localparam int BpSettle    = 16;
   // Request FIFO, the memory's response slot and the response FIFO, plus margin
   localparam int BpLimit     = 2 * Depth + 1 + 3;

   typedef struct packed {
      logic                      write;
      logic [`CDC_ADDR_W-1:0]    addr;
      logic [`CDC_DATA_W-1:0]    wdata;
      logic [7:0]                stall;
      cdc_bridge_pkg::rsp_chan_t exp;
   } entry_t;

   logic                   clk_sys;
   logic                   rst_n_i;
   logic                   req_valid_i;
   logic                   req_ready_o;
   logic [`CDC_ADDR_W-1:0] req_addr_i;
   logic [`CDC_DATA_W-1:0] req_wdata_i;
   logic                   req_write_i;
   logic                   rsp_valid_o;
   logic                   rsp_ready_i;
   logic [`CDC_DATA_W-1:0] rsp_rdata_o;
   logic                   rsp_err_o;

   entry_t                 table_q [$];
   logic [`CDC_DATA_W-1:0] ref_mem [`CDC_MEM_WORDS];
   logic [31:0]            rng_state;

   cdc_bridge_top dut_i (
      .clk_sys     (clk_sys),
      .rst_n_i     (rst_n_i),
      .req_valid_i (req_valid_i),
      .req_ready_o (req_ready_o),
      .req_addr_i  (req_addr_i),
      .req_wdata_i (req_wdata_i),
      .req_write_i (req_write_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_ready_i (rsp_ready_i),
      .rsp_rdata_o (rsp_rdata_o),
      .rsp_err_o   (rsp_err_o)
   );

   bind cdc_fifo_src cdc_bridge_checker u_fifo_chk (
      .clk_sys    (clk_sys),
      .rst_n_i    (rst_n_i),
      .gray_ptr_i (wptr_o),
      .peer_ptr_i (rptr_i),
      .src_side_i (1'b1),
      .valid_i    (valid_i),
      .ready_i    (ready_o)
   );

   bind cdc_fifo_dst cdc_bridge_checker u_fifo_chk (
      .clk_sys    (clk_sys),
      .rst_n_i    (rst_n_i),
      .gray_ptr_i (rptr_o),
      .peer_ptr_i (wptr_i),
      .src_side_i (1'b0),
      .valid_i    (valid_o),
      .ready_i    (ready_i)
   );

   always #20 clk_sys = ~clk_sys;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Expected response follows the memory rules, applied in request order
   function automatic void add_entry(input logic write, input logic [`CDC_ADDR_W-1:0] addr,
                                     input logic [`CDC_DATA_W-1:0] wdata, input int stall);
      entry_t e;
      e.write = write;
      e.addr  = addr;
      e.wdata = wdata;
      e.stall = 8'(stall);
      if (int'(addr) >= `CDC_MEM_WORDS) begin
         e.exp.rdata = '0;
         e.exp.err   = 1'b1;
      end else if (write) begin
         ref_mem[addr[IdxW-1:0]] = wdata;
         e.exp.rdata = '0;
         e.exp.err   = 1'b0;
      end else begin
         e.exp.rdata = ref_mem[addr[IdxW-1:0]];
         e.exp.err   = 1'b0;
      end
      table_q.push_back(e);
   endfunction

   function automatic void add_random_entry(input int addr_span, input int max_stall);
      logic [31:0] r;
      logic [31:0] d;
      int          a;
      int          s;
      r = next_rand();
      d = next_rand();
      a = int'(r[15:8]) % addr_span;
      s = (max_stall == 0) ? 0 : int'(r[23:16]) % (max_stall + 1);
      add_entry(r[0], `CDC_ADDR_W'(a), d[`CDC_DATA_W-1:0], s);
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_rsp(input int idx, input cdc_bridge_pkg::rsp_chan_t got,
                            input cdc_bridge_pkg::rsp_chan_t exp);
      if (got.rdata !== exp.rdata) begin
         stop_on_error($sformatf("ERROR t=%0t entry %0d rsp_rdata_o got %h expected %h",
                                 $time, idx, got.rdata, exp.rdata));
      end
      if (got.err !== exp.err) begin
         stop_on_error($sformatf("ERROR t=%0t entry %0d rsp_err_o got %b expected %b",
                                 $time, idx, got.err, exp.err));
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_on_error($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   // Called on a falling edge, returns on the falling edge after the transfer
   task automatic send_request(input int idx);
      int waited;
      waited      = 0;
      req_valid_i = 1'b1;
      req_addr_i  = table_q[idx].addr;
      req_wdata_i = table_q[idx].wdata;
      req_write_i = table_q[idx].write;
      while (!req_ready_o) begin
         @(negedge clk_sys);
         waited++;
         if (waited > ReqTimeout) begin
            stop_on_error($sformatf("Request %0d was never accepted", idx));
         end
      end
      @(negedge clk_sys);
   endtask

   task automatic take_response(input int idx);
      cdc_bridge_pkg::rsp_chan_t got;
      int                        waited;
      waited = 0;
      if (table_q[idx].stall != 0) begin
         rsp_ready_i = 1'b0;
         repeat (table_q[idx].stall) @(negedge clk_sys);
      end
      rsp_ready_i = 1'b1;
      while (!rsp_valid_o) begin
         @(negedge clk_sys);
         waited++;
         if (waited > RspTimeout) begin
            stop_on_error($sformatf("No response arrived for request %0d", idx));
         end
      end
      got.rdata = rsp_rdata_o;
      got.err   = rsp_err_o;
      check_rsp(idx, got, table_q[idx].exp);
      @(negedge clk_sys);
   endtask

   // Issue and collect run side by side so the burst stays back to back
   task automatic run_entries(input int first, input int last);
      fork
         begin
            for (int i = first; i < last; i++) begin
               send_request(i);
            end
            req_valid_i = 1'b0;
         end
         begin
            for (int j = first; j < last; j++) begin
               take_response(j);
            end
         end
      join
   endtask

   task automatic run_backpressure();
      int first;
      int accepted;
      int low_run;
      int waited;
      first    = table_q.size();
      accepted = 0;
      low_run  = 0;
      waited   = 0;
      rsp_ready_i = 1'b0;
      // Keep issuing until req_ready_o has stayed low long enough to be settled
      while (low_run < BpSettle) begin
         if (req_ready_o) begin
            if (accepted >= BpLimit) begin
               stop_on_error($sformatf("req_ready_o still high after %0d accepted requests",
                                       accepted));
            end
            add_random_entry(`CDC_MEM_WORDS, 0);
            send_request(table_q.size() - 1);
            accepted++;
            low_run = 0;
         end else begin
            req_valid_i = 1'b0;
            low_run++;
            @(negedge clk_sys);
         end
         waited++;
         if (waited > BpTimeout) begin
            stop_on_error("Back-pressure phase did not settle in time");
         end
      end
      req_valid_i = 1'b0;
      check_level("req_ready_o", req_ready_o, 1'b0);
      check_level("rsp_valid_o", rsp_valid_o, 1'b1);
      for (int j = first; j < table_q.size(); j++) begin
         take_response(j);
      end
   endtask

   function automatic int assert_failures();
      return dut_i.i_req_src.u_fifo_chk.fail_count + dut_i.i_req_dst.u_fifo_chk.fail_count
           + dut_i.i_rsp_src.u_fifo_chk.fail_count + dut_i.i_rsp_dst.u_fifo_chk.fail_count;
   endfunction

   // Stop at the first checker assertion failure
   always @(negedge clk_sys) begin
      if (assert_failures() != 0) begin
         stop_on_error("A checker assertion failed inside a crossing FIFO");
      end
   end

   initial begin
      clk_sys     = 1'b0;
      rst_n_i     = 1'b0;
      req_valid_i = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      req_write_i = 1'b0;
      rsp_ready_i = 1'b0;
      rng_state   = 32'h33f5_9abf;

      repeat (8) @(posedge clk_sys);
      @(negedge clk_sys);
      rst_n_i = 1'b1;
      @(negedge clk_sys);
      check_level("rsp_valid_o", rsp_valid_o, 1'b0);
      check_level("req_ready_o", req_ready_o, 1'b1);

      // Random fill so that every word is known
      for (int a = 0; a < `CDC_MEM_WORDS; a++) begin
         add_entry(1'b1, `CDC_ADDR_W'(a), `CDC_DATA_W'(next_rand() >> 16), 0);
      end
      // Write then read back
      add_entry(1'b1, 8'h15, 16'hbeef, 0);
      add_entry(1'b0, 8'h15, 16'h0000, 2);
      // Out of range, then the aliased and neighboring words
      add_entry(1'b1, 8'h40, 16'h1234, 0);
      add_entry(1'b0, 8'h00, 16'h0000, 1);
      add_entry(1'b0, 8'h3f, 16'h0000, 0);
      add_entry(1'b0, 8'hc8, 16'h0000, 3);
      add_entry(1'b1, 8'hff, 16'h5a5a, 0);
      add_entry(1'b0, 8'h3f, 16'h0000, 0);
      add_entry(1'b0, 8'h3e, 16'h0000, 0);
      // Back-to-back burst, a few out of range
      for (int k = 0; k < 12; k++) begin
         add_random_entry(72, 0);
      end
      // Mixed traffic with random response stalls
      for (int k = 0; k < 10; k++) begin
         add_random_entry(`CDC_MEM_WORDS, 5);
      end

      run_entries(0, table_q.size());
      run_backpressure();

      if (assert_failures() == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("Checker assertions failed %0d times", assert_failures());
         $display("Test failed");
         $fatal(1);
      end
   end

endmodule

//--- cdc_bridge.f
+incdir+include
logic/cdc_bridge_pkg.sv
logic/cdc_fifo_src.sv
logic/cdc_fifo_dst.sv
logic/scratch_mem.sv
logic/cdc_bridge_top.sv
sim/cdc_bridge_checker.sv
sim/cdc_bridge_tb.sv

//--- Makefile
# Verilator build and run for the bridge testbench

SIM      ?= verilator
TOP      ?= cdc_bridge_tb
FILELIST ?= cdc_bridge.f
BUILD    ?= obj_dir
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with $(SIM)"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD)
